/* Makefile */
TOP = cpuCoreTb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f files.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* design/cpuCore.sv */
/*
 * three-stage integer core
 * decode, execute and result stages around the register file
 */
`include "cpuParams.svh"

module cpuCore (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic [`DATA_WIDTH-1:0] instr,
	output logic inReady,
	output logic retireValid,
	output cpuPkg::regWrite_t retire,
	input logic retireReady
);

	logic [`REG_ADDR_WIDTH-1:0] rsIdx, rtIdx;
	logic [`DATA_WIDTH-1:0] rsVal, rtVal;
	logic decValid, execReady;
	cpuPkg::decoded_t dec;
	cpuPkg::regWrite_t fwdExec, ex;
	logic fwdExecValid, exValid, resultReady;
	logic wrEn;

	regFile u_regFile (
		.clk, .arstN, .rsIdx, .rtIdx, .wrEn,
		.wr(retire), // retire record is the write
		.rsVal, .rtVal
	);

	decodeStage u_decodeStage (
		.clk, .arstN, .inValid, .instr, .inReady,
		.rsIdx, .rtIdx, .rsVal, .rtVal,
		.fwdExec, .fwdExecValid,
		.fwdRes(ex), .fwdResValid(exValid),
		.fwdRet(retire), .fwdRetValid(retireValid),
		.decValid, .dec, .execReady
	);

	executeStage u_executeStage (
		.clk, .arstN, .decValid, .dec, .execReady,
		.fwdExec, .fwdExecValid, .exValid, .ex, .resultReady
	);

	resultStage u_resultStage (
		.clk, .arstN, .exValid, .ex, .resultReady,
		.retireValid, .retire, .retireReady, .wrEn
	);

endmodule

/* design/cpuPkg.sv */
/*
 * CPU core package
 * opcode and ALU encodings, pipeline record types
 */
`include "cpuParams.svh"

package cpuPkg;

	// instruction opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_ADD = 6'd0,
		OP_SUB = 6'd1,
		OP_AND = 6'd2,
		OP_OR = 6'd3,
		OP_XOR = 6'd4,
		OP_SLT = 6'd5,
		OP_ADDI = 6'd8,
		OP_ORI = 6'd9,
		OP_LUI = 6'd10
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} aluOp_t;

	// result headed for the register file
	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0] value;
	} regWrite_t;

	// decode to execute record
	typedef struct packed {
		aluOp_t aluOp;
		logic immSel; // operand B from imm
		logic zeroA; // LUI: operand A forced to zero
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0] opA; // forwarded rs
		logic [`DATA_WIDTH-1:0] opB; // forwarded rt
		logic [`DATA_WIDTH-1:0] imm;
	} decoded_t;

endpackage

/* design/decodeStage.sv */
/*
 * decode stage
 * field split, opcode decode, operand forwarding, decode register
 */
`include "cpuParams.svh"

module decodeStage (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic [`DATA_WIDTH-1:0] instr,
	output logic inReady,
	output logic [`REG_ADDR_WIDTH-1:0] rsIdx,
	output logic [`REG_ADDR_WIDTH-1:0] rtIdx,
	input logic [`DATA_WIDTH-1:0] rsVal,
	input logic [`DATA_WIDTH-1:0] rtVal,
	input cpuPkg::regWrite_t fwdExec,
	input cpuPkg::regWrite_t fwdRes,
	input cpuPkg::regWrite_t fwdRet,
	input logic fwdExecValid,
	input logic fwdResValid,
	input logic fwdRetValid,
	output logic decValid,
	output cpuPkg::decoded_t dec,
	input logic execReady
);

	cpuPkg::opcode_t opcode;
	logic [`REG_ADDR_WIDTH-1:0] rdIdx;
	logic [`CONST_WIDTH-1:0] constant;
	logic [`DATA_WIDTH-1:0] constZext;
	logic [`DATA_WIDTH-1:0] rsFwd, rtFwd;
	cpuPkg::decoded_t decNext;
	logic opKnown;

	assign opcode = cpuPkg::opcode_t'(instr[31:26]);
	assign rsIdx = instr[24:20];
	assign rtIdx = instr[19:15];
	assign rdIdx = instr[14:10];
	assign constant = instr[14:0]; // overlaps rd
	assign constZext = {{(`DATA_WIDTH-`CONST_WIDTH){1'b0}}, constant};

	// newest in-flight result wins, register file last
	function automatic logic [`DATA_WIDTH-1:0] pickOperand(
		input logic [`REG_ADDR_WIDTH-1:0] idx,
		input logic [`DATA_WIDTH-1:0] rfVal
	);
		if (fwdExecValid && fwdExec.dest == idx)
			return fwdExec.value;
		else if (fwdResValid && fwdRes.dest == idx)
			return fwdRes.value;
		else if (fwdRetValid && fwdRet.dest == idx)
			return fwdRet.value;
		return rfVal;
	endfunction

	always_comb begin
		rsFwd = pickOperand(rsIdx, rsVal);
		rtFwd = pickOperand(rtIdx, rtVal);
	end

	always_comb begin
		decNext = '0;
		opKnown = 1'b1;
		decNext.opA = rsFwd;
		decNext.opB = rtFwd;
		decNext.dest = rdIdx; // register forms write rd
		case (opcode)
			cpuPkg::OP_ADD: decNext.aluOp = cpuPkg::ALU_ADD;
			cpuPkg::OP_SUB: decNext.aluOp = cpuPkg::ALU_SUB;
			cpuPkg::OP_AND: decNext.aluOp = cpuPkg::ALU_AND;
			cpuPkg::OP_OR: decNext.aluOp = cpuPkg::ALU_OR;
			cpuPkg::OP_XOR: decNext.aluOp = cpuPkg::ALU_XOR;
			cpuPkg::OP_SLT: decNext.aluOp = cpuPkg::ALU_SLT;
			cpuPkg::OP_ADDI: begin
				decNext.aluOp = cpuPkg::ALU_ADD;
				decNext.immSel = 1'b1;
				decNext.dest = rtIdx;
				decNext.imm = {{(`DATA_WIDTH-`CONST_WIDTH){constant[`CONST_WIDTH-1]}}, constant};
			end
			cpuPkg::OP_ORI: begin
				decNext.aluOp = cpuPkg::ALU_OR;
				decNext.immSel = 1'b1;
				decNext.dest = rtIdx;
				decNext.imm = constZext;
			end
			cpuPkg::OP_LUI: begin
				// 0 | (const << 17)
				decNext.aluOp = cpuPkg::ALU_OR;
				decNext.immSel = 1'b1;
				decNext.zeroA = 1'b1;
				decNext.dest = rtIdx;
				decNext.imm = constZext << `LUI_SHIFT;
			end
			default: opKnown = 1'b0; // dropped here, never retires
		endcase
	end

	assign inReady = !decValid || execReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			decValid <= 1'b0;
		else if (inReady)
			decValid <= inValid && opKnown;
	end

	always_ff @(posedge clk) begin
		if (inReady && inValid)
			dec <= decNext;
	end

endmodule

/* design/executeStage.sv */
/*
 * execute stage
 * operand select, ALU and the execute register
 */
`include "cpuParams.svh"

module executeStage (
	input logic clk,
	input logic arstN,
	input logic decValid,
	input cpuPkg::decoded_t dec,
	output logic execReady,
	output cpuPkg::regWrite_t fwdExec,
	output logic fwdExecValid,
	output logic exValid,
	output cpuPkg::regWrite_t ex,
	input logic resultReady
);

	logic [`DATA_WIDTH-1:0] aluA, aluB, aluOut;

	assign aluA = dec.zeroA ? '0 : dec.opA;
	assign aluB = dec.immSel ? dec.imm : dec.opB;

	always_comb begin
		case (dec.aluOp)
			cpuPkg::ALU_ADD: aluOut = aluA + aluB;
			cpuPkg::ALU_SUB: aluOut = aluA - aluB;
			cpuPkg::ALU_AND: aluOut = aluA & aluB;
			cpuPkg::ALU_OR: aluOut = aluA | aluB;
			cpuPkg::ALU_XOR: aluOut = aluA ^ aluB;
			cpuPkg::ALU_SLT: begin
				// signed compare
				aluOut = ($signed(aluA) < $signed(aluB)) ? `DATA_WIDTH'd1 : '0;
			end
			default: aluOut = '0;
		endcase
	end

	// newest forwarding source
	assign fwdExec.dest = dec.dest;
	assign fwdExec.value = aluOut;
	assign fwdExecValid = decValid;

	assign execReady = !exValid || resultReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			exValid <= 1'b0;
		else if (execReady)
			exValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (execReady && decValid)
			ex <= fwdExec;
	end

endmodule

/* design/regFile.sv */
/*
 * register file, 32 words
 * two combinational read ports, one write port
 */
`include "cpuParams.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic [`REG_ADDR_WIDTH-1:0] rsIdx,
	input logic [`REG_ADDR_WIDTH-1:0] rtIdx,
	input logic wrEn,
	input cpuPkg::regWrite_t wr,
	output logic [`DATA_WIDTH-1:0] rsVal,
	output logic [`DATA_WIDTH-1:0] rtVal
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0; // every register starts at zero
		end else if (wrEn) begin
			regs[wr.dest] <= wr.value;
		end
	end

	assign rsVal = regs[rsIdx];
	assign rtVal = regs[rtIdx];

endmodule

/* design/resultStage.sv */
/*
 * result stage
 * retire register, output handshake and register file write
 */
module resultStage (
	input logic clk,
	input logic arstN,
	input logic exValid,
	input cpuPkg::regWrite_t ex,
	output logic resultReady,
	output logic retireValid,
	output cpuPkg::regWrite_t retire,
	input logic retireReady,
	output logic wrEn
);

	// free when empty or the record leaves this cycle
	assign resultReady = !retireValid || retireReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			retireValid <= 1'b0;
		else if (resultReady)
			retireValid <= exValid;
	end

	always_ff @(posedge clk) begin
		if (resultReady && exValid)
			retire <= ex; // held while retireReady is low
	end

	// register file takes the record on the transfer edge
	assign wrEn = retireValid && retireReady;

endmodule

/* files.f */
+incdir+include
design/cpuPkg.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/cpuCore.sv
tests/clockGen.sv
tests/cpuCoreTb.sv

/* include/cpuParams.svh */
/*
 * CPU core parameters
 * word, register file and instruction constant widths
 */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_WIDTH 32 // datapath word
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5 // rs/rt/rd field width

// constant field of the immediate forms
`define CONST_WIDTH 15
`define LUI_SHIFT 17 // puts the constant in bits 31:17

`endif

/* tests/clockGen.sv */
/*
 * testbench clock and reset
 * 40 ns clock, reset held low for the first two cycles
 */
module clockGen (
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		#1 arstN = 1'b1; // released just after the second edge
	end

endmodule

/* tests/cpuCoreTb.sv */
/*
 * cpuCore testbench
 * reference model in program order, retire checks, random back-pressure
 */
`include "cpuParams.svh"

module cpuCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 50;
	localparam int DRAIN_LIMIT = 400;
	localparam logic [5:0] DISCARD_OPS [6] = '{6'd6, 6'd7, 6'd11, 6'd12, 6'd33, 6'd63};

	logic clk, arstN;
	logic inValid, inReady, retireValid, retireReady;
	logic [`DATA_WIDTH-1:0] instr;
	cpuPkg::regWrite_t retire;

	cpuPkg::regWrite_t expQ[$]; // expected retire records, oldest first
	cpuPkg::regWrite_t expected, heldRecord;
	logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
	logic [5:0] validOps [9];
	logic holdPending, stallMode, timedOut;
	int seed, errors, checked, testsRun, errBefore;

	clockGen u_clockGen (.clk, .arstN);

	cpuCore u_cpuCore (
		.clk, .arstN, .inValid, .instr, .inReady,
		.retireValid, .retire, .retireReady
	);

	task automatic reportMismatch(input string sig, input logic [31:0] got,
			input logic [31:0] want);
		$display("Error at %0d ns: %s = %h, expected %h", $time, sig, got, want);
		errors++;
	endtask

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic logic [4:0] pickReg(input int lo, input int count);
		return 5'(lo + randBelow(count));
	endfunction

	// random stalls on the retire side
	always @(posedge clk) begin
		#1;
		retireReady = stallMode ? (randBelow(2) == 1) : 1'b1;
	end

	// retire monitor, samples mid-cycle
	always @(negedge clk) begin
		if (arstN) begin
			if (holdPending) begin
				assert (retireValid) else begin
					$display("retireValid dropped at %0d ns before its record transferred", $time);
					errors++;
				end
				assert (retire.dest === heldRecord.dest)
					else reportMismatch("retire.dest", 32'(retire.dest), 32'(heldRecord.dest));
				assert (retire.value === heldRecord.value)
					else reportMismatch("retire.value", retire.value, heldRecord.value);
			end
			holdPending = retireValid && !retireReady;
			heldRecord = retire;
			if (retireValid && retireReady) begin
				if (expQ.size() == 0) begin
					$display("unexpected retire record for r%0d at %0d ns", retire.dest, $time);
					errors++;
				end else begin
					expected = expQ.pop_front();
					checked++;
					assert (retire.dest === expected.dest)
						else reportMismatch("retire.dest", 32'(retire.dest), 32'(expected.dest));
					assert (retire.value === expected.value)
						else reportMismatch("retire.value", retire.value, expected.value);
				end
			end
		end
	end

	task automatic checkIdle();
		assert (retireValid === 1'b0) else reportMismatch("retireValid", 32'(retireValid), 32'd0);
		assert (inReady === 1'b1) else reportMismatch("inReady", 32'(inReady), 32'd1);
	endtask

	// leaves inValid high so instructions go back to back
	task automatic sendInstr(input logic [31:0] word);
		int waited;
		waited = 0;
		if (!timedOut) begin
			inValid = 1'b1;
			instr = word;
			@(negedge clk);
			while (!inReady && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!inReady) begin
				$display("core never accepted instruction %h", word);
				errors++;
				timedOut = 1'b1;
			end else begin
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic issue(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [14:0] k);
		logic [31:0] word, a, b;
		cpuPkg::regWrite_t rec;
		logic writes;
		a = model[rs];
		b = model[rt];
		writes = 1'b1;
		rec.dest = rd;
		rec.value = '0;
		word = {op, 1'b0, rs, rt, rd, 10'd0};
		case (op)
			cpuPkg::OP_ADD: rec.value = a + b;
			cpuPkg::OP_SUB: rec.value = a - b;
			cpuPkg::OP_AND: rec.value = a & b;
			cpuPkg::OP_OR: rec.value = a | b;
			cpuPkg::OP_XOR: rec.value = a ^ b;
			cpuPkg::OP_SLT: rec.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpuPkg::OP_ADDI: rec.value = a + {{(`DATA_WIDTH-`CONST_WIDTH){k[14]}}, k};
			cpuPkg::OP_ORI: rec.value = a | {{(`DATA_WIDTH-`CONST_WIDTH){1'b0}}, k};
			cpuPkg::OP_LUI: rec.value = {k, `LUI_SHIFT'd0};
			default: writes = 1'b0;
		endcase
		if (op == cpuPkg::OP_ADDI || op == cpuPkg::OP_ORI || op == cpuPkg::OP_LUI) begin
			rec.dest = rt; // immediate forms write rt
			word = {op, 1'b0, rs, rt, k};
		end
		if (writes) begin
			model[rec.dest] = rec.value;
			expQ.push_back(rec);
		end
		sendInstr(word);
	endtask

	// bits 16:15 stay clear, LUI and ORI cannot reach them
	task automatic loadReg(input logic [4:0] r, input logic [31:0] v);
		issue(cpuPkg::OP_LUI, 5'd0, r, 5'd0, v[31:17]);
		issue(cpuPkg::OP_ORI, r, r, 5'd0, v[14:0]);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		inValid = 1'b0;
		while (expQ.size() != 0 && waited < DRAIN_LIMIT && !timedOut) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0 && !timedOut) begin
			$display("%0d expected records never retired", expQ.size());
			errors++;
			timedOut = 1'b1;
		end
		repeat (4) @(posedge clk); // quiet window, extra records get caught
		#2;
	endtask

	task automatic finishTest(input string name);
		$display("test %-12s %s, %0d errors", name,
			(errors == errBefore) ? "ok" : "failed", errors - errBefore);
		testsRun++;
		errBefore = errors;
	endtask

	initial begin
		int waited;
		logic [4:0] dst, prev;
		seed = 32'hd5fb;
		errors = 0;
		checked = 0;
		testsRun = 0;
		errBefore = 0;
		waited = 0;
		inValid = 1'b0;
		instr = '0;
		retireReady = 1'b1;
		stallMode = 1'b0;
		timedOut = 1'b0;
		holdPending = 1'b0;
		for (int r = 0; r < `REG_COUNT; r++)
			model[r] = '0;
		validOps = '{cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_OR,
			cpuPkg::OP_XOR, cpuPkg::OP_SLT, cpuPkg::OP_ADDI, cpuPkg::OP_ORI, cpuPkg::OP_LUI};

		do begin
			@(negedge clk);
			checkIdle();
			waited++;
		end while (!arstN && waited < WAIT_LIMIT);
		if (!arstN) begin
			$display("reset never released");
			errors++;
			timedOut = 1'b1;
		end
		@(negedge clk);
		checkIdle();
		@(posedge clk);
		#2;
		finishTest("reset");

		issue(cpuPkg::OP_LUI, 5'd0, 5'd1, 5'd0, 15'h4001);
		issue(cpuPkg::OP_ADDI, 5'd1, 5'd2, 5'd0, 15'h7ff0); // -16
		issue(cpuPkg::OP_ADDI, 5'd0, 5'd3, 5'd0, 15'h3fff);
		issue(cpuPkg::OP_ADDI, 5'd0, 5'd4, 5'd0, 15'h4000); // most negative
		issue(cpuPkg::OP_ORI, 5'd1, 5'd5, 5'd0, 15'h7fff);
		loadReg(5'd6, 32'h5a5a_1234);
		loadReg(5'd7, $random(seed));
		drain();
		finishTest("immediate");

		loadReg(5'd1, 32'hf000_0003); // negative operand for slt
		// negative r1 against zero, both orders
		issue(cpuPkg::OP_SLT, 5'd1, 5'd0, 5'd9, 15'd0);
		issue(cpuPkg::OP_SLT, 5'd0, 5'd1, 5'd10, 15'd0);
		for (int i = 2; i <= 8; i++)
			loadReg(5'(i), $random(seed));
		repeat (30)
			issue(validOps[randBelow(6)], pickReg(1, 8), pickReg(1, 8), pickReg(1, 8), 15'd0);
		drain();
		finishTest("registerOps");

		// rs reads the result d instructions back, rt the one just before
		for (int d = 1; d <= 3; d++) begin
			for (int i = 0; i < 12; i++) begin
				dst = 5'(9 + i % d);
				prev = 5'(9 + (i + d - 1) % d);
				case (i % 4)
					0: issue(cpuPkg::OP_ADD, dst, prev, dst, 15'd0);
					1: issue(cpuPkg::OP_ADDI, prev, dst, 5'd0, 15'(randBelow(32768)));
					2: issue(cpuPkg::OP_SUB, dst, prev, dst, 15'd0);
					default: issue(cpuPkg::OP_XOR, dst, prev, dst, 15'd0);
				endcase
			end
		end
		drain();
		finishTest("forwarding");

		stallMode = 1'b1;
		repeat (40)
			issue(validOps[randBelow(9)], pickReg(1, 12), pickReg(1, 12), pickReg(1, 12),
				15'(randBelow(32768)));
		drain();
		stallMode = 1'b0;
		finishTest("backPressure");

		for (int i = 0; i < 6; i++) begin
			issue(validOps[randBelow(9)], pickReg(1, 12), pickReg(1, 12), pickReg(1, 12),
				15'(randBelow(32768)));
			issue(DISCARD_OPS[i], pickReg(1, 12), pickReg(1, 12), pickReg(1, 12),
				15'(randBelow(32768)));
		end
		drain();
		finishTest("discard");

		$display("tests %0d, records checked %0d, errors %0d", testsRun, checked, errors);
		if (errors == 0 && !timedOut)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
